//--- csr_types_pkg.sv
package csr_types_pkg;

    // rv64 only
    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] csr_data_t;
    typedef logic [11:0] csr_addr_t;

    // one pmp entry config byte: L, 2 reserved, A[1:0], X, W, R
    typedef logic [7:0] pmp_cfg_byte_t;

    // rv64 packs eight cfg bytes into each even pmpcfg
    localparam int PMPCFG_BYTES = XLEN / $bits(pmp_cfg_byte_t);

    // pmpcfg0 + pmpcfg2
    localparam int MAX_PMP_ENTRIES = 2 * PMPCFG_BYTES;

    localparam int PMP_CFG_BUS_W = MAX_PMP_ENTRIES * $bits(pmp_cfg_byte_t);

    // mstatus.UXL lives at [33:32]
    localparam int UXL_LSB = 32;

endpackage

//--- csr_addr_pkg.sv
package csr_addr_pkg;

    // machine information, read-only
    localparam csr_types_pkg::csr_addr_t CSR_MVENDORID  = 12'hF11;
    localparam csr_types_pkg::csr_addr_t CSR_MARCHID    = 12'hF12;
    localparam csr_types_pkg::csr_addr_t CSR_MIMPID     = 12'hF13;
    localparam csr_types_pkg::csr_addr_t CSR_MHARTID    = 12'hF14;
    localparam csr_types_pkg::csr_addr_t CSR_MCONFIGPTR = 12'hF15;

    // trap setup
    localparam csr_types_pkg::csr_addr_t CSR_MSTATUS    = 12'h300;
    localparam csr_types_pkg::csr_addr_t CSR_MISA       = 12'h301;
    localparam csr_types_pkg::csr_addr_t CSR_MEDELEG    = 12'h302;
    localparam csr_types_pkg::csr_addr_t CSR_MIDELEG    = 12'h303;
    localparam csr_types_pkg::csr_addr_t CSR_MIE        = 12'h304;
    localparam csr_types_pkg::csr_addr_t CSR_MTVEC      = 12'h305;
    localparam csr_types_pkg::csr_addr_t CSR_MCOUNTEREN = 12'h306;

    // trap handling
    localparam csr_types_pkg::csr_addr_t CSR_MSCRATCH   = 12'h340;
    localparam csr_types_pkg::csr_addr_t CSR_MEPC       = 12'h341;
    localparam csr_types_pkg::csr_addr_t CSR_MCAUSE     = 12'h342;
    localparam csr_types_pkg::csr_addr_t CSR_MTVAL      = 12'h343;
    localparam csr_types_pkg::csr_addr_t CSR_MIP        = 12'h344;

    // memory protection, even cfg regs only on rv64
    localparam csr_types_pkg::csr_addr_t CSR_PMPCFG0    = 12'h3A0;
    localparam csr_types_pkg::csr_addr_t CSR_PMPCFG2    = 12'h3A2;

    localparam csr_types_pkg::csr_addr_t CSR_PMPADDR_BASE = 12'h3B0;
    // last number the cfg regs can describe
    localparam csr_types_pkg::csr_addr_t CSR_PMPADDR_LAST =
        CSR_PMPADDR_BASE + csr_types_pkg::csr_addr_t'(csr_types_pkg::MAX_PMP_ENTRIES - 1);

endpackage

//--- machine_csr_bank.sv
`timescale 1ns/10ps

module machine_csr_bank (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_clk_en,
    input  logic                      i_csr_we,
    input  csr_types_pkg::csr_addr_t  i_csr_waddr,
    input  csr_types_pkg::csr_data_t  i_csr_wdata,
    input  csr_types_pkg::csr_addr_t  i_csr_raddr,
    output logic                      o_hit,
    output csr_types_pkg::csr_data_t  o_rdata,
    output csr_types_pkg::csr_data_t  o_mepc,
    output csr_types_pkg::csr_data_t  o_mtvec,
    output logic [1:0]                o_uxl
);

    import csr_types_pkg::*;
    import csr_addr_pkg::*;

    csr_data_t r_mstatus, r_misa, r_medeleg, r_mideleg;
    csr_data_t r_mie, r_mtvec, r_mcounteren, r_mscratch;
    csr_data_t r_mepc, r_mcause, r_mtval, r_mip;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            r_mstatus    <= '0;
            r_misa       <= '0;
            r_medeleg    <= '0;
            r_mideleg    <= '0;
            r_mie        <= '0;
            r_mtvec      <= '0;
            r_mcounteren <= '0;
            r_mscratch   <= '0;
            r_mepc       <= '0;
            r_mcause     <= '0;
            r_mtval      <= '0;
            r_mip        <= '0;
        end
        else if (i_clk_en && i_csr_we)
        begin
            case (i_csr_waddr)
                CSR_MSTATUS:    r_mstatus    <= i_csr_wdata;
                CSR_MISA:       r_misa       <= i_csr_wdata;
                CSR_MEDELEG:    r_medeleg    <= i_csr_wdata;
                CSR_MIDELEG:    r_mideleg    <= i_csr_wdata;
                CSR_MIE:        r_mie        <= i_csr_wdata;
                CSR_MTVEC:      r_mtvec      <= i_csr_wdata;
                CSR_MCOUNTEREN: r_mcounteren <= i_csr_wdata;
                CSR_MSCRATCH:   r_mscratch   <= i_csr_wdata;
                CSR_MEPC:       r_mepc       <= i_csr_wdata;
                CSR_MCAUSE:     r_mcause     <= i_csr_wdata;
                CSR_MTVAL:      r_mtval      <= i_csr_wdata;
                CSR_MIP:        r_mip        <= i_csr_wdata;
                default: ; // id regs and foreign numbers
            endcase
        end
    end

    always_comb
    begin
        o_hit   = 1'b1;
        o_rdata = '0;
        case (i_csr_raddr)
            // single hart, no vendor info
            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID,
            CSR_MHARTID, CSR_MCONFIGPTR: o_rdata = '0;
            CSR_MSTATUS:    o_rdata = r_mstatus;
            CSR_MISA:       o_rdata = r_misa;
            CSR_MEDELEG:    o_rdata = r_medeleg;
            CSR_MIDELEG:    o_rdata = r_mideleg;
            CSR_MIE:        o_rdata = r_mie;
            CSR_MTVEC:      o_rdata = r_mtvec;
            CSR_MCOUNTEREN: o_rdata = r_mcounteren;
            CSR_MSCRATCH:   o_rdata = r_mscratch;
            CSR_MEPC:       o_rdata = r_mepc;
            CSR_MCAUSE:     o_rdata = r_mcause;
            CSR_MTVAL:      o_rdata = r_mtval;
            CSR_MIP:        o_rdata = r_mip;
            default:        o_hit   = 1'b0; // not ours
        endcase
    end

    assign o_mepc  = r_mepc;
    assign o_mtvec = r_mtvec;
    assign o_uxl   = r_mstatus[UXL_LSB +: 2];

endmodule

//--- pmp_csr_bank.sv
`timescale 1ns/10ps

module pmp_csr_bank #(
    parameter int PMP_ENTRIES = 8
) (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_clk_en,
    input  logic                      i_csr_we,
    input  csr_types_pkg::csr_addr_t  i_csr_waddr,
    input  csr_types_pkg::csr_data_t  i_csr_wdata,
    input  csr_types_pkg::csr_addr_t  i_csr_raddr,
    output logic                      o_hit,
    output csr_types_pkg::csr_data_t  o_rdata,
    output logic [PMP_ENTRIES*csr_types_pkg::XLEN-1:0] o_pmp_addr_bus,
    output logic [csr_types_pkg::PMP_CFG_BUS_W-1:0]    o_pmp_cfg_bus
);

    import csr_types_pkg::*;
    import csr_addr_pkg::*;

    localparam int CFG_W = $bits(pmp_cfg_byte_t);

    csr_data_t r_pmpcfg0;
    csr_data_t r_pmpcfg2;
    csr_data_t r_pmpaddr [PMP_ENTRIES];

    csr_addr_t w_offset, r_offset; // entry index within the pmpaddr block
    logic      r_in_range;

    assign w_offset   = i_csr_waddr - CSR_PMPADDR_BASE;
    assign r_offset   = i_csr_raddr - CSR_PMPADDR_BASE;
    assign r_in_range = (i_csr_raddr >= CSR_PMPADDR_BASE) && (i_csr_raddr <= CSR_PMPADDR_LAST);

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            r_pmpcfg0 <= '0;
            r_pmpcfg2 <= '0;
            for (int n = 0; n < PMP_ENTRIES; n++)
                r_pmpaddr[n] <= '0;
        end
        else if (i_clk_en && i_csr_we)
        begin
            if (i_csr_waddr == CSR_PMPCFG0)
                r_pmpcfg0 <= i_csr_wdata;
            if (i_csr_waddr == CSR_PMPCFG2)
                r_pmpcfg2 <= i_csr_wdata;
            // entries past PMP_ENTRIES never match
            for (int n = 0; n < PMP_ENTRIES; n++)
                if (i_csr_waddr >= CSR_PMPADDR_BASE && w_offset == csr_addr_t'(n))
                    r_pmpaddr[n] <= i_csr_wdata;
        end
    end

    always_comb
    begin
        o_hit   = 1'b1;
        o_rdata = '0;
        if (i_csr_raddr == CSR_PMPCFG0)
            o_rdata = r_pmpcfg0;
        else if (i_csr_raddr == CSR_PMPCFG2)
            o_rdata = r_pmpcfg2;
        else if (r_in_range)
        begin
            for (int n = 0; n < PMP_ENTRIES; n++)
                if (r_offset == csr_addr_t'(n))
                    o_rdata = r_pmpaddr[n];
        end
        else
            o_hit = 1'b0;
    end

    // cfg bytes: pmpcfg0 fills entries 0..7, pmpcfg2 entries 8..15
    always_comb
    begin
        for (int b = 0; b < PMPCFG_BYTES; b++)
        begin
            o_pmp_cfg_bus[b*CFG_W +: CFG_W]                  = r_pmpcfg0[b*CFG_W +: CFG_W];
            o_pmp_cfg_bus[(b+PMPCFG_BYTES)*CFG_W +: CFG_W]   = r_pmpcfg2[b*CFG_W +: CFG_W];
        end
        for (int n = 0; n < PMP_ENTRIES; n++)
            o_pmp_addr_bus[n*XLEN +: XLEN] = r_pmpaddr[n];
    end

endmodule

//--- csr_read_port.sv
`timescale 1ns/10ps

module csr_read_port (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_clk_en,
    input  logic                      i_machine_hit,
    input  logic                      i_pmp_hit,
    input  csr_types_pkg::csr_data_t  i_machine_rdata,
    input  csr_types_pkg::csr_data_t  i_pmp_rdata,
    output csr_types_pkg::csr_data_t  o_csr_rdata
);

    import csr_types_pkg::*;

    csr_data_t sel_data;
    csr_data_t r_rdata;

    // banks decode disjoint ranges, so at most one hit is set
    assign sel_data = ({XLEN{i_machine_hit}} & i_machine_rdata)
                    | ({XLEN{i_pmp_hit}}     & i_pmp_rdata);

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            r_rdata <= '0;
        else if (i_clk_en)
            r_rdata <= sel_data; // pre-edge value, no write bypass
    end

    assign o_csr_rdata = r_rdata;

endmodule

//--- csr_reg_file.sv
`timescale 1ns/10ps

module csr_reg_file #(
    parameter int PMP_ENTRIES = 8
) (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_clk_en,
    input  logic                      i_csr_we,
    input  csr_types_pkg::csr_addr_t  i_csr_waddr,
    input  csr_types_pkg::csr_data_t  i_csr_wdata,
    input  csr_types_pkg::csr_addr_t  i_csr_raddr,
    output csr_types_pkg::csr_data_t  o_csr_rdata,
    output csr_types_pkg::csr_data_t  o_mepc,
    output csr_types_pkg::csr_data_t  o_mtvec,
    output logic [1:0]                o_uxl,
    output logic [PMP_ENTRIES*csr_types_pkg::XLEN-1:0] o_pmp_addr_bus,
    output logic [csr_types_pkg::PMP_CFG_BUS_W-1:0]    o_pmp_cfg_bus
);

    import csr_types_pkg::*;

    logic      machine_hit, pmp_hit;
    csr_data_t machine_rdata, pmp_rdata;

    machine_csr_bank machine_csr_bank_inst (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_clk_en    (i_clk_en),
        .i_csr_we    (i_csr_we),
        .i_csr_waddr (i_csr_waddr),
        .i_csr_wdata (i_csr_wdata),
        .i_csr_raddr (i_csr_raddr),
        .o_hit       (machine_hit),
        .o_rdata     (machine_rdata),
        .o_mepc      (o_mepc),
        .o_mtvec     (o_mtvec),
        .o_uxl       (o_uxl)
    );

    pmp_csr_bank #(
        .PMP_ENTRIES (PMP_ENTRIES)
    ) pmp_csr_bank_inst (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_clk_en       (i_clk_en),
        .i_csr_we       (i_csr_we),
        .i_csr_waddr    (i_csr_waddr),
        .i_csr_wdata    (i_csr_wdata),
        .i_csr_raddr    (i_csr_raddr),
        .o_hit          (pmp_hit),
        .o_rdata        (pmp_rdata),
        .o_pmp_addr_bus (o_pmp_addr_bus),
        .o_pmp_cfg_bus  (o_pmp_cfg_bus)
    );

    csr_read_port csr_read_port_inst (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_clk_en        (i_clk_en),
        .i_machine_hit   (machine_hit),
        .i_pmp_hit       (pmp_hit),
        .i_machine_rdata (machine_rdata),
        .i_pmp_rdata     (pmp_rdata),
        .o_csr_rdata     (o_csr_rdata)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic o_clk,
    output logic o_rst
);

    initial
    begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial
    begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0; // released away from the sampling edge
    end

endmodule

//--- csr_checker.sv
`timescale 1ns/10ps

module csr_checker #(
    parameter int PMP_ENTRIES = 8
) (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_clk_en,
    input  logic                      i_csr_we,
    input  csr_types_pkg::csr_addr_t  i_csr_waddr,
    input  csr_types_pkg::csr_data_t  i_csr_wdata,
    input  csr_types_pkg::csr_addr_t  i_csr_raddr,
    input  csr_types_pkg::csr_data_t  i_csr_rdata,
    input  csr_types_pkg::csr_data_t  i_mepc,
    input  csr_types_pkg::csr_data_t  i_mtvec,
    input  logic [1:0]                i_uxl,
    input  logic [PMP_ENTRIES*csr_types_pkg::XLEN-1:0] i_pmp_addr_bus,
    input  logic [csr_types_pkg::PMP_CFG_BUS_W-1:0]    i_pmp_cfg_bus,
    input  int                        i_test_id,
    input  logic                      i_test_end,
    output int                        o_checks,
    output int                        o_errors
);

    import csr_types_pkg::*;
    import csr_addr_pkg::*;

    csr_data_t model [4096]; // indexed by csr number
    csr_data_t pend_exp;
    logic      pend_valid = 1'b0;
    logic      seen_reset = 1'b0;
    int        pend_test  = 0;
    int        checks     = 0;
    int        errors     = 0;
    int        checks_mark = 0;
    int        errors_mark = 0;

    function automatic string test_label(input int id);
        case (id)
            1:       return "reset_values";
            2:       return "trap_regs";
            3:       return "read_only";
            4:       return "pmp_regs";
            5:       return "clk_en_hold";
            6:       return "mstatus_uxl";
            default: return "idle";
        endcase
    endfunction

    function automatic logic implemented(input csr_addr_t a);
        return (a >= CSR_MSTATUS && a <= CSR_MCOUNTEREN)
            || (a >= CSR_MSCRATCH && a <= CSR_MIP)
            || a == CSR_PMPCFG0 || a == CSR_PMPCFG2
            || (a >= CSR_PMPADDR_BASE && a < CSR_PMPADDR_BASE + PMP_ENTRIES);
    endfunction

    // id regs, unknown numbers and missing pmpaddr read zero
    function automatic csr_data_t expected_read(input csr_addr_t a);
        return implemented(a) ? model[a] : '0;
    endfunction

    task automatic compare(input string what, input csr_data_t exp, input csr_data_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("error %s %s: expected %h, actual %h",
                     test_label(pend_test), what, exp, act);
        end
    endtask

    always @(posedge i_clk)
    begin
        pend_test  <= i_test_id;
        pend_valid <= i_rst || seen_reset;
        if (i_rst)
        begin
            seen_reset <= 1'b1;
            pend_exp   <= '0;
            for (int a = 0; a < 4096; a++)
                model[a] <= '0;
        end
        else if (i_clk_en)
        begin
            pend_exp <= expected_read(i_csr_raddr); // model still pre-edge here
            if (i_csr_we && implemented(i_csr_waddr))
                model[i_csr_waddr] <= i_csr_wdata;
        end
        if (i_test_end)
        begin
            $display("test %s: %0d checks, %0d errors", test_label(i_test_id),
                     checks - checks_mark, errors - errors_mark);
            checks_mark <= checks;
            errors_mark <= errors;
        end
    end

    always @(negedge i_clk)
    begin
        if (pend_valid)
        begin
            compare("rdata", pend_exp, i_csr_rdata);
            compare("mepc", model[CSR_MEPC], i_mepc);
            compare("mtvec", model[CSR_MTVEC], i_mtvec);
            compare("uxl", csr_data_t'(model[CSR_MSTATUS][UXL_LSB +: 2]), csr_data_t'(i_uxl));
            // pmpcfg0 bytes in the low half, pmpcfg2 bytes above
            compare("cfg bus pmpcfg0", model[CSR_PMPCFG0], i_pmp_cfg_bus[0 +: XLEN]);
            compare("cfg bus pmpcfg2", model[CSR_PMPCFG2], i_pmp_cfg_bus[XLEN +: XLEN]);
            for (int n = 0; n < PMP_ENTRIES; n++)
                compare($sformatf("addr bus slot %0d", n), model[CSR_PMPADDR_BASE + n],
                        i_pmp_addr_bus[n*XLEN +: XLEN]);
        end
    end

    assign o_checks = checks;
    assign o_errors = errors;

endmodule

//--- csr_reg_file_assertions.sv
`timescale 1ns/10ps

module csr_reg_file_assertions (
    input logic                     i_clk,
    input logic                     i_rst,
    input logic                     i_clk_en,
    input logic                     i_csr_we,
    input csr_types_pkg::csr_addr_t i_csr_waddr,
    input csr_types_pkg::csr_data_t i_csr_wdata,
    input csr_types_pkg::csr_data_t i_csr_rdata,
    input logic [1:0]               i_uxl
);

    import csr_types_pkg::*;
    import csr_addr_pkg::*;

    rdata_holds: assert property (@(posedge i_clk)
        (!i_rst && !i_clk_en) |=> $stable(i_csr_rdata))
        else $error("read data changed while the clock enable was low");

    rdata_zero_after_reset: assert property (@(posedge i_clk)
        i_rst |=> (i_csr_rdata == '0))
        else $error("read data not zero after reset");

    // uxl taken from the written mstatus word
    uxl_follows_write: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_clk_en && i_csr_we && i_csr_waddr == CSR_MSTATUS)
        |=> (i_uxl == $past(i_csr_wdata[UXL_LSB +: 2])))
        else $error("uxl output does not follow the mstatus write");

endmodule

bind csr_reg_file csr_reg_file_assertions csr_reg_file_assertions_inst (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_clk_en    (i_clk_en),
    .i_csr_we    (i_csr_we),
    .i_csr_waddr (i_csr_waddr),
    .i_csr_wdata (i_csr_wdata),
    .i_csr_rdata (o_csr_rdata),
    .i_uxl       (o_uxl)
);

//--- tb_csr_reg_file.sv
`timescale 1ns/10ps

module tb_csr_reg_file;

    import csr_types_pkg::*;
    import csr_addr_pkg::*;

    localparam int PMP_ENTRIES = 8;
    localparam int CLK_PERIOD  = 20;
    // reset, six tests, two cycles per end-of-test
    localparam int TEST_CYCLES = 2 + 27 + 24 + 36 + 20 + 6 + 8 + 6 * 2;
    localparam int TIMEOUT_NS  = (TEST_CYCLES + 50) * CLK_PERIOD;

    logic      clk, rst, clk_en, csr_we, test_end;
    csr_addr_t csr_waddr, csr_raddr;
    csr_data_t csr_wdata, csr_rdata, mepc, mtvec;
    logic [1:0] uxl;
    logic [PMP_ENTRIES*XLEN-1:0] pmp_addr_bus;
    logic [PMP_CFG_BUS_W-1:0]    pmp_cfg_bus;
    int        test_id, checks, errors;
    logic [31:0] lfsr_state = 32'd91;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) tb_clock_gen_inst (
        .o_clk (clk),
        .o_rst (rst)
    );

    csr_reg_file #(.PMP_ENTRIES(PMP_ENTRIES)) csr_reg_file_inst (
        .i_clk (clk), .i_rst (rst), .i_clk_en (clk_en), .i_csr_we (csr_we),
        .i_csr_waddr (csr_waddr), .i_csr_wdata (csr_wdata), .i_csr_raddr (csr_raddr),
        .o_csr_rdata (csr_rdata), .o_mepc (mepc), .o_mtvec (mtvec), .o_uxl (uxl),
        .o_pmp_addr_bus (pmp_addr_bus), .o_pmp_cfg_bus (pmp_cfg_bus)
    );

    csr_checker #(.PMP_ENTRIES(PMP_ENTRIES)) csr_checker_inst (
        .i_clk (clk), .i_rst (rst), .i_clk_en (clk_en), .i_csr_we (csr_we),
        .i_csr_waddr (csr_waddr), .i_csr_wdata (csr_wdata), .i_csr_raddr (csr_raddr),
        .i_csr_rdata (csr_rdata), .i_mepc (mepc), .i_mtvec (mtvec), .i_uxl (uxl),
        .i_pmp_addr_bus (pmp_addr_bus), .i_pmp_cfg_bus (pmp_cfg_bus),
        .i_test_id (test_id), .i_test_end (test_end), .o_checks (checks), .o_errors (errors)
    );

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic rand_word(output csr_data_t v);
        v = '0;
        for (int i = 0; i < XLEN; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[XLEN-2:0], lfsr_state[0]};
        end
    endtask

    task automatic drive_cycle(input logic en, input logic we, input csr_addr_t waddr,
                               input csr_data_t wdata, input csr_addr_t raddr);
        @(negedge clk);
        clk_en    = en;
        csr_we    = we;
        csr_waddr = waddr;
        csr_wdata = wdata;
        csr_raddr = raddr;
    endtask

    task automatic read_csr(input csr_addr_t a);
        drive_cycle(1'b1, 1'b0, a, '0, a);
    endtask

    task automatic read_range(input int lo, input int hi);
        for (int a = lo; a <= hi; a++)
            read_csr(csr_addr_t'(a));
    endtask

    task automatic write_read(input csr_addr_t a);
        csr_data_t v;
        rand_word(v);
        drive_cycle(1'b1, 1'b1, a, v, a);
        read_csr(a); // sampled one edge after the write
    endtask

    task automatic write_read_range(input int lo, input int hi);
        for (int a = lo; a <= hi; a++)
            write_read(csr_addr_t'(a));
    endtask

    task automatic end_test();
        drive_cycle(1'b1, 1'b0, '0, '0, '0);
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    initial
    begin
        csr_data_t v;
        clk_en    = 1'b1;
        csr_we    = 1'b0;
        csr_waddr = '0;
        csr_wdata = '0;
        csr_raddr = '0;
        test_id   = 0;
        test_end  = 1'b0;
        wait (!rst);

        test_id = 1;
        read_range(CSR_MSTATUS, CSR_MCOUNTEREN);
        read_range(CSR_MSCRATCH, CSR_MIP);
        read_range(CSR_MVENDORID, CSR_MCONFIGPTR);
        read_csr(CSR_PMPCFG0);
        read_csr(CSR_PMPCFG2);
        read_range(CSR_PMPADDR_BASE, CSR_PMPADDR_BASE + PMP_ENTRIES - 1);
        end_test();

        test_id = 2;
        write_read_range(CSR_MSTATUS, CSR_MCOUNTEREN);
        write_read_range(CSR_MSCRATCH, CSR_MIP);
        end_test();

        test_id = 3;
        write_read_range(CSR_MVENDORID, CSR_MCONFIGPTR);
        write_read(12'h000);
        write_read(12'h3A1); // odd cfg regs are rv32 only
        write_read(12'h3A3);
        write_read(12'h3C0);
        write_read(12'h7C0);
        write_read_range(CSR_PMPADDR_BASE + PMP_ENTRIES, CSR_PMPADDR_BASE + MAX_PMP_ENTRIES - 1);
        end_test();

        test_id = 4;
        write_read(CSR_PMPCFG0);
        write_read(CSR_PMPCFG2);
        write_read_range(CSR_PMPADDR_BASE, CSR_PMPADDR_BASE + PMP_ENTRIES - 1);
        end_test();

        test_id = 5;
        write_read(CSR_MSCRATCH);
        rand_word(v);
        repeat (3) drive_cycle(1'b0, 1'b1, CSR_MSCRATCH, v, CSR_MEPC); // gated off
        read_csr(CSR_MSCRATCH);
        end_test();

        test_id = 6;
        repeat (4)
        begin
            rand_word(v);
            drive_cycle(1'b1, 1'b1, CSR_MSTATUS, v, CSR_MSTATUS); // old value on this edge
            read_csr(CSR_MSTATUS);
        end
        end_test();

        @(posedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- verilog.f
csr_types_pkg.sv
csr_addr_pkg.sv
machine_csr_bank.sv
pmp_csr_bank.sv
csr_read_port.sv
csr_reg_file.sv
tb_clock_gen.sv
csr_checker.sv
csr_reg_file_assertions.sv
tb_csr_reg_file.sv

//--- Bender.yml
package:
  name: csr_reg_file

sources:
  - files:
      - csr_types_pkg.sv
      - csr_addr_pkg.sv
      - machine_csr_bank.sv
      - pmp_csr_bank.sv
      - csr_read_port.sv
      - csr_reg_file.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - csr_checker.sv
      - csr_reg_file_assertions.sv
      - tb_csr_reg_file.sv
